/* Makefile */
VERILATOR  ?= verilator
TOP        ?= ip_top_tb
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation completed successfully
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides, not the exit code of the binary
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS: $(TOP)" || \
		(echo "FAIL: $(TOP), see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/ip_cfg.svh */
`ifndef IP_CFG_SVH
`define IP_CFG_SVH

// buffer sizes in bytes
`define IP_FIFO_DEPTH  2048
`define IP_ICMP_DEPTH  512
`define IP_PKT_DEPTH   16    // packets queued per source
`define IP_FULL_MARGIN 64    // user_full asserts below this much free space

`define IP_TTL         64
`define IP_HDR_LEN     20

`endif

/* logic/icmp_echo.sv */
`timescale 1ns/1ps
`include "ip_cfg.svh"

module icmp_echo (
  input  logic               clk,
  input  logic               rst_n,
  input  ip_pkg::ip_stream_t rx,
  input  ip_pkg::ip_meta_t   rx_meta,
  output ip_pkg::ip_stream_t tx,
  output ip_pkg::ip_meta_t   meta
);

  localparam int DEPTH = `IP_ICMP_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  ip_pkg::icmp_state_t state;
  ip_pkg::byte_t       ram [DEPTH];
  ip_pkg::byte_t       ram_q;
  ip_pkg::len_t        wa;
  ip_pkg::len_t        ra;
  ip_pkg::len_t        pos;
  ip_pkg::len_t        ilen;
  ip_pkg::csum_t       csum;
  ip_pkg::csum_t       csum_rep;
  logic                rd_v;
  logic                req;

  // echo request that fits in the buffer
  assign req = state == ip_pkg::ICMP_IDLE && rx.valid && rx.sof && !rx.eof &&
               rx_meta.proto == 8'd1 && rx.data == 8'd8 &&
               rx_meta.len >= 16'd8 && rx_meta.len <= ip_pkg::len_t'(DEPTH);

  // type 8 -> 0 lowers the sum by 0x0800
  assign csum_rep = ip_pkg::csum_add(csum, 16'h0800);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ip_pkg::ICMP_IDLE;
      wa    <= '0;
      ra    <= '0;
      pos   <= '0;
      rd_v  <= 1'b0;
    end else begin
      rd_v <= 1'b0;
      case (state)
        ip_pkg::ICMP_IDLE: begin
          wa <= 16'd1;
          ra <= '0;
          if (req) state <= ip_pkg::ICMP_CAPTURE;
        end
        ip_pkg::ICMP_CAPTURE: if (rx.valid) begin
          wa <= wa + 16'd1;
          if (rx.eof) state <= rx.err ? ip_pkg::ICMP_IDLE : ip_pkg::ICMP_REPLY;
        end
        ip_pkg::ICMP_REPLY: begin
          if (ra != ilen) begin
            rd_v <= 1'b1;
            pos  <= ra;
            ra   <= ra + 16'd1;
          end
          if (tx.eof) state <= ip_pkg::ICMP_IDLE;
        end
        default: state <= ip_pkg::ICMP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ip_pkg::ICMP_CAPTURE && rx.valid) begin
      ram[wa[AW-1:0]] <= rx.data;
      if (wa == 16'd2) csum[15:8] <= rx.data;
      if (wa == 16'd3) csum[7:0] <= rx.data;
      if (rx.eof) ilen <= wa + 16'd1;
    end
    if (state == ip_pkg::ICMP_REPLY && ra != ilen) ram_q <= ram[ra[AW-1:0]];
    if (req) begin
      meta.src   <= rx_meta.dst;
      meta.dst   <= rx_meta.src;   // back to the sender
      meta.proto <= 8'd1;
      meta.len   <= rx_meta.len;
    end
  end

  always_comb begin
    tx       = '0;
    tx.valid = rd_v;
    tx.sof   = rd_v && pos == 16'd0;
    tx.eof   = rd_v && pos == ilen - 16'd1;
    case (pos)
      16'd0:   tx.data = 8'h00;        // echo reply
      16'd2:   tx.data = csum_rep[15:8];
      16'd3:   tx.data = csum_rep[7:0];
      default: tx.data = ram_q;
    endcase
  end

  a_tx_reply: assert property (@(posedge clk) disable iff (!rst_n)
    tx.valid |-> state == ip_pkg::ICMP_REPLY);

endmodule

/* logic/ip_pkg.sv */
package ip_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] ipv4_t;
  typedef logic [15:0] len_t;
  typedef logic [7:0]  proto_t;
  typedef logic [15:0] csum_t;

  typedef struct packed {
    byte_t data;
    logic  valid;
    logic  sof;
    logic  eof;
    logic  err;
  } ip_stream_t;

  typedef struct packed {
    ipv4_t  src;
    ipv4_t  dst;
    proto_t proto;
    len_t   len;   // payload bytes, header excluded
  } ip_meta_t;

  typedef enum logic [1:0] {RX_IDLE, RX_HDR, RX_PAYLOAD, RX_DROP} rx_state_t;
  typedef enum logic [1:0] {TX_IDLE, TX_HDR, TX_PAYLOAD} tx_state_t;
  typedef enum logic [1:0] {ICMP_IDLE, ICMP_CAPTURE, ICMP_REPLY} icmp_state_t;

  // ones' complement add with end-around carry
  function automatic csum_t csum_add(csum_t a, csum_t b);
    logic [16:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[15:0] + {15'd0, s[16]};
  endfunction

endpackage

/* logic/ip_top.sv */
`timescale 1ns/1ps

module ip_top (
  input  logic               clk,
  input  logic               rst_n,
  input  ip_pkg::ipv4_t      dev_ip,
  input  ip_pkg::ip_stream_t mac_rx,
  output ip_pkg::ip_stream_t mac_tx,
  output ip_pkg::ip_stream_t user_rx,
  output ip_pkg::ip_meta_t   user_rx_meta,
  input  ip_pkg::ip_stream_t user_tx,
  input  ip_pkg::ip_meta_t   user_tx_meta,
  output logic               user_full
);

  ip_pkg::ip_stream_t rx_pay;
  ip_pkg::ip_meta_t   rx_meta;
  ip_pkg::ip_stream_t icmp_tx;
  ip_pkg::ip_meta_t   icmp_meta;
  ip_pkg::ip_stream_t arb_out;
  ip_pkg::ip_meta_t   arb_meta;
  logic               arb_avl;
  logic               arb_pop;
  logic               tx_busy;

  assign user_rx      = rx_pay;
  assign user_rx_meta = rx_meta;

  ipv4_rx u_rx (
    .clk    (clk),
    .rst_n  (rst_n),
    .mac_rx (mac_rx),
    .dev_ip (dev_ip),
    .pay    (rx_pay),
    .meta   (rx_meta)
  );

  icmp_echo u_icmp (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx_pay),
    .rx_meta (rx_meta),
    .tx      (icmp_tx),
    .meta    (icmp_meta)
  );

  // source 0 is ICMP, source 1 the user
  tx_arbiter u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .src0      (icmp_tx),
    .src0_meta (icmp_meta),
    .src1      (user_tx),
    .src1_meta (user_tx_meta),
    .full1     (user_full),
    .pop       (arb_pop),
    .avl       (arb_avl),
    .out       (arb_out),
    .out_meta  (arb_meta)
  );

  ipv4_tx u_tx (
    .clk    (clk),
    .rst_n  (rst_n),
    .dev_ip (dev_ip),
    .avl    (arb_avl),
    .meta   (arb_meta),
    .pay    (arb_out),
    .pop    (arb_pop),
    .busy   (tx_busy),
    .mac_tx (mac_tx)
  );

endmodule

/* logic/ipv4_rx.sv */
`timescale 1ns/1ps
`include "ip_cfg.svh"

module ipv4_rx (
  input  logic               clk,
  input  logic               rst_n,
  input  ip_pkg::ip_stream_t mac_rx,
  input  ip_pkg::ipv4_t      dev_ip,
  output ip_pkg::ip_stream_t pay,
  output ip_pkg::ip_meta_t   meta
);

  localparam logic [4:0] LAST_HDR = 5'(`IP_HDR_LEN - 1);

  ip_pkg::rx_state_t state;
  logic [4:0]        cnt;
  logic [159:0]      hdr;
  logic [159:0]      hdr_nxt;
  ip_pkg::csum_t     sum;
  ip_pkg::csum_t     sum_nxt;
  ip_pkg::len_t      tot_len;
  ip_pkg::len_t      rem;
  logic              first;
  logic              hdr_done;
  logic              hdr_ok;

  assign hdr_nxt  = {hdr[151:0], mac_rx.data};
  assign sum_nxt  = ip_pkg::csum_add(sum, {hdr[7:0], mac_rx.data});
  assign tot_len  = hdr_nxt[143:128];
  assign hdr_done = state == ip_pkg::RX_HDR && mac_rx.valid && cnt == LAST_HDR;

  // judged as the 20th byte goes by
  assign hdr_ok = hdr_nxt[159:152] == 8'h45 &&               // v4, no options
                  hdr_nxt[109:96] == '0 &&                     // no MF, offset 0
                  tot_len > ip_pkg::len_t'(`IP_HDR_LEN) &&
                  hdr_nxt[31:0] == dev_ip &&
                  sum_nxt == 16'hffff;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ip_pkg::RX_IDLE;
      cnt   <= '0;
      sum   <= '0;
      rem   <= '0;
      first <= 1'b0;
      pay   <= '0;
    end else begin
      pay.valid <= 1'b0;
      pay.sof   <= 1'b0;
      pay.eof   <= 1'b0;
      pay.err   <= 1'b0;
      case (state)
        ip_pkg::RX_IDLE: begin
          sum <= '0;
          cnt <= 5'd1;
          if (mac_rx.valid && mac_rx.sof && !mac_rx.eof) state <= ip_pkg::RX_HDR;
        end
        ip_pkg::RX_HDR: if (mac_rx.valid) begin
          cnt <= cnt + 5'd1;
          if (cnt[0]) sum <= sum_nxt;  // second byte of a word
          if (mac_rx.eof) begin
            state <= ip_pkg::RX_IDLE;   // runt, nothing delivered
          end else if (hdr_done) begin
            state <= hdr_ok ? ip_pkg::RX_PAYLOAD : ip_pkg::RX_DROP;
            rem   <= tot_len - ip_pkg::len_t'(`IP_HDR_LEN);
            first <= 1'b1;
          end
        end
        ip_pkg::RX_PAYLOAD: if (mac_rx.valid) begin
          pay.data  <= mac_rx.data;
          pay.valid <= 1'b1;
          pay.sof   <= first;
          pay.eof   <= mac_rx.eof || rem == 16'd1;
          pay.err   <= mac_rx.eof && rem != 16'd1;  // cut short
          first     <= 1'b0;
          rem       <= rem - 16'd1;
          if (mac_rx.eof) state <= ip_pkg::RX_IDLE;
          else if (rem == 16'd1) state <= ip_pkg::RX_DROP;  // eat the padding
        end
        ip_pkg::RX_DROP: if (mac_rx.valid && mac_rx.eof) state <= ip_pkg::RX_IDLE;
        default: state <= ip_pkg::RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mac_rx.valid && (state == ip_pkg::RX_IDLE || state == ip_pkg::RX_HDR)) hdr <= hdr_nxt;
    if (hdr_done && hdr_ok && !mac_rx.eof) begin
      meta.src   <= hdr_nxt[63:32];
      meta.dst   <= hdr_nxt[31:0];
      meta.proto <= hdr_nxt[87:80];
      meta.len   <= tot_len - ip_pkg::len_t'(`IP_HDR_LEN);
    end
  end

  // mid-packet bytes never leave the parser idle
  a_pay_src: assert property (@(posedge clk) disable iff (!rst_n)
    pay.valid && !pay.eof |-> state == ip_pkg::RX_PAYLOAD);

endmodule

/* logic/ipv4_tx.sv */
`timescale 1ns/1ps
`include "ip_cfg.svh"

module ipv4_tx (
  input  logic               clk,
  input  logic               rst_n,
  input  ip_pkg::ipv4_t      dev_ip,
  input  logic               avl,
  input  ip_pkg::ip_meta_t   meta,
  input  ip_pkg::ip_stream_t pay,
  output logic               pop,
  output logic               busy,
  output ip_pkg::ip_stream_t mac_tx
);

  localparam logic [4:0] LAST_HDR = 5'(`IP_HDR_LEN - 1);

  ip_pkg::tx_state_t state;
  logic [159:0]      hdr;
  logic [159:0]      hdr_sr;
  logic [4:0]        cnt;
  ip_pkg::len_t      tot_len;
  ip_pkg::len_t      ident;
  ip_pkg::len_t      left;   // pops still owed to the arbiter
  ip_pkg::csum_t     sum;
  ip_pkg::csum_t     csum;
  logic              start;

  assign busy  = state != ip_pkg::TX_IDLE || mac_tx.valid;
  assign start = !busy && avl;
  // popping at the last header byte lands the payload right behind it
  assign pop   = left != '0 &&
                 ((state == ip_pkg::TX_HDR && cnt == LAST_HDR) || state == ip_pkg::TX_PAYLOAD);

  always_comb begin
    tot_len = meta.len + 16'(`IP_HDR_LEN);
    sum     = ip_pkg::csum_add(16'h4500, tot_len);
    sum     = ip_pkg::csum_add(sum, ident);
    sum     = ip_pkg::csum_add(sum, 16'h4000);   // DF
    sum     = ip_pkg::csum_add(sum, {8'(`IP_TTL), meta.proto});
    sum     = ip_pkg::csum_add(sum, dev_ip[31:16]);
    sum     = ip_pkg::csum_add(sum, dev_ip[15:0]);
    sum     = ip_pkg::csum_add(sum, meta.dst[31:16]);
    sum     = ip_pkg::csum_add(sum, meta.dst[15:0]);
    csum    = ~sum;
    hdr     = {16'h4500, tot_len, ident, 16'h4000, 8'(`IP_TTL), meta.proto,
               csum, dev_ip, meta.dst};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= ip_pkg::TX_IDLE;
      cnt    <= '0;
      ident  <= '0;
      left   <= '0;
      mac_tx <= '0;
    end else begin
      mac_tx.valid <= 1'b0;
      mac_tx.sof   <= 1'b0;
      mac_tx.eof   <= 1'b0;
      mac_tx.err   <= 1'b0;
      if (pop) left <= left - 16'd1;
      case (state)
        ip_pkg::TX_IDLE: if (start) begin
          state        <= ip_pkg::TX_HDR;
          cnt          <= 5'd1;
          left         <= meta.len;
          ident        <= ident + 16'd1;
          mac_tx.valid <= 1'b1;
          mac_tx.sof   <= 1'b1;
          mac_tx.data  <= hdr[159:152];
        end
        ip_pkg::TX_HDR: begin
          cnt          <= cnt + 5'd1;
          mac_tx.valid <= 1'b1;
          mac_tx.data  <= hdr_sr[159:152];
          if (cnt == LAST_HDR) state <= ip_pkg::TX_PAYLOAD;
        end
        ip_pkg::TX_PAYLOAD: if (pay.valid) begin
          mac_tx.valid <= 1'b1;
          mac_tx.data  <= pay.data;
          mac_tx.eof   <= pay.eof;
          if (pay.eof) state <= ip_pkg::TX_IDLE;
        end
        default: state <= ip_pkg::TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) hdr_sr <= {hdr[151:0], 8'h00};
    else if (state == ip_pkg::TX_HDR) hdr_sr <= {hdr_sr[151:0], 8'h00};
  end

  a_eof_valid: assert property (@(posedge clk) disable iff (!rst_n)
    mac_tx.eof |-> mac_tx.valid);

  // no bubble between sof and eof
  a_no_gap: assert property (@(posedge clk) disable iff (!rst_n)
    mac_tx.valid && !mac_tx.eof |=> mac_tx.valid);

endmodule

/* logic/tx_arbiter.sv */
`timescale 1ns/1ps
`include "ip_cfg.svh"

module tx_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  input  ip_pkg::ip_stream_t src0,
  input  ip_pkg::ip_meta_t   src0_meta,
  input  ip_pkg::ip_stream_t src1,
  input  ip_pkg::ip_meta_t   src1_meta,
  output logic               full1,
  input  logic               pop,
  output logic               avl,
  output ip_pkg::ip_stream_t out,
  output ip_pkg::ip_meta_t   out_meta
);

  localparam int DEPTH = `IP_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int PD    = `IP_PKT_DEPTH;
  localparam int PW    = $clog2(PD);

  typedef logic [AW:0] ptr_t;
  typedef logic [PW:0] qptr_t;

  ip_pkg::ip_stream_t in_s    [2];
  ip_pkg::ip_meta_t   in_m    [2];
  ip_pkg::ip_meta_t   head    [2];
  logic [8:0]         rd_data [2];
  logic               pkt_avl [2];
  logic               full    [2];
  logic               active;
  logic               gnt;
  logic               pref;
  logic               sel;
  logic               pop_ok;
  logic               last_pop;
  logic               out_v;
  logic               out_first;
  logic               out_src;
  ip_pkg::len_t       pop_cnt;

  assign in_s[0] = src0;
  assign in_s[1] = src1;
  assign in_m[0] = src0_meta;
  assign in_m[1] = src1_meta;
  assign full1   = full[1];

  for (genvar i = 0; i < 2; i++) begin : g_fifo
    logic [8:0]       mem [DEPTH];  // {eof, data}
    ip_pkg::ip_meta_t pq  [PD];
    ip_pkg::ip_meta_t pend;
    ip_pkg::ip_meta_t cur;
    ip_pkg::len_t     bcnt;
    ptr_t             wp;
    ptr_t             rp;
    ptr_t             used;
    qptr_t            qwp;
    qptr_t            qrp;
    logic [8:0]       q;
    logic             wr;
    logic             rd;

    assign used       = wp - rp;
    assign full[i]    = used > ptr_t'(DEPTH - `IP_FULL_MARGIN) || qptr_t'(qwp - qrp) == qptr_t'(PD);
    assign wr         = in_s[i].valid && !full[i];
    assign rd         = pop_ok && gnt == 1'(i);
    assign pkt_avl[i] = qwp != qrp;   // only complete packets count
    assign head[i]    = pq[qrp[PW-1:0]];
    assign rd_data[i] = q;
    assign cur        = (bcnt == '0) ? in_m[i] : pend;  // dst/proto from first byte

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        wp   <= '0;
        rp   <= '0;
        qwp  <= '0;
        qrp  <= '0;
        bcnt <= '0;
      end else begin
        if (wr) begin
          wp   <= wp + 1'b1;
          bcnt <= in_s[i].eof ? '0 : bcnt + 16'd1;
          if (in_s[i].eof) qwp <= qwp + 1'b1;
        end
        if (rd) begin
          rp <= rp + 1'b1;
          if (last_pop) qrp <= qrp + 1'b1;
        end
      end
    end

    always_ff @(posedge clk) begin
      if (wr) begin
        mem[wp[AW-1:0]] <= {in_s[i].eof, in_s[i].data};
        if (bcnt == '0) pend <= in_m[i];
        if (in_s[i].eof) pq[qwp[PW-1:0]] <= '{src: cur.src, dst: cur.dst,
                                                proto: cur.proto, len: bcnt + 16'd1};
      end
      if (rd) q <= mem[rp[AW-1:0]];
    end

    a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
      in_s[i].valid |-> !full[i]);
  end

  assign sel      = active ? gnt : (pkt_avl[pref] ? pref : ~pref);
  assign avl      = pkt_avl[sel];
  assign out_meta = head[sel];
  assign pop_ok   = pop && active;
  assign last_pop = pop_cnt == head[gnt].len - 16'd1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active    <= 1'b0;
      gnt       <= 1'b0;
      pref      <= 1'b0;   // source 0 first
      pop_cnt   <= '0;
      out_v     <= 1'b0;
      out_first <= 1'b0;
      out_src   <= 1'b0;
    end else begin
      out_v     <= pop_ok;
      out_first <= pop_ok && pop_cnt == '0;
      out_src   <= gnt;
      if (!active && pkt_avl[sel]) begin
        active  <= 1'b1;
        gnt     <= sel;
        pref    <= ~sel;
        pop_cnt <= '0;
      end else if (pop_ok) begin
        pop_cnt <= last_pop ? '0 : pop_cnt + 16'd1;
        if (last_pop) active <= 1'b0;   // grant held until eof leaves
      end
    end
  end

  always_comb begin
    out.data  = rd_data[out_src][7:0];
    out.valid = out_v;
    out.sof   = out_first;
    out.eof   = out_v && rd_data[out_src][8];
    out.err   = 1'b0;
  end

endmodule

/* src.f */
+incdir+include
logic/ip_pkg.sv
logic/ipv4_rx.sv
logic/icmp_echo.sv
logic/tx_arbiter.sv
logic/ipv4_tx.sv
logic/ip_top.sv
tb/tb_clkgen.sv
tb/ip_top_tb.sv

/* tb/ip_top_tb.sv */
`timescale 1ns/1ps
`include "ip_cfg.svh"

module ip_top_tb;

  localparam ip_pkg::ipv4_t DEV_IP   = 32'hc0a8010a;
  localparam ip_pkg::ipv4_t PEER     = 32'hc0a80114;
  localparam ip_pkg::ipv4_t PINGER   = 32'hc0a80163;
  localparam ip_pkg::ipv4_t USER_DST = 32'hc0a80177;
  localparam int USER_LEN   = 37;
  localparam int UDP_LEN    = 26;
  localparam int TRUNC_LEN  = 40;   // payload length the header claims
  localparam int TRUNC_SENT = 20;
  localparam int ICMP_LEN   = 32;
  localparam int HDR        = `IP_HDR_LEN;
  // all bytes in and out over the six tests
  localparam int EXP_BYTES  = 4 * USER_LEN + 4 * UDP_LEN + 2 * TRUNC_SENT +
                              6 * ICMP_LEN + 10 * HDR;
  localparam int TIMEOUT    = 40 * EXP_BYTES + 2000;

  logic               clk;
  logic               rst_n;
  ip_pkg::ipv4_t      dev_ip;
  ip_pkg::ip_stream_t mac_rx;
  ip_pkg::ip_stream_t mac_tx;
  ip_pkg::ip_stream_t user_rx;
  ip_pkg::ip_meta_t   user_rx_meta;
  ip_pkg::ip_stream_t user_tx;
  ip_pkg::ip_meta_t   user_tx_meta;
  logic               user_full;

  logic [7:0]       pay_q [$];    // payload of the next MAC frame
  logic [7:0]       pkt_q [$];
  logic [7:0]       user_q [$];
  logic [7:0]       icmp_q [$];
  logic [7:0]       tx_bytes [$];
  int               tx_lens [$];
  logic [7:0]       cur_q [$];    // last packet taken off mac_tx
  logic [7:0]       rx_bytes [$];
  ip_pkg::ip_meta_t rx_meta_seen;
  logic             rx_last_err = 1'b0;
  int               rx_pkts = 0;
  int               tx_cnt = 0;
  logic             tx_open = 1'b0;
  logic             rx_allowed = 1'b0;
  logic             tx_allowed = 1'b0;
  logic [31:0]      rng = 32'h7e600f3c;
  int               errors = 0;
  int               checks = 0;
  int               tests = 0;
  int               test_base = 0;
  int               cycles = 0;

  tb_clkgen #(.PERIOD_NS(100)) u_clk (.clk(clk));

  ip_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .dev_ip       (dev_ip),
    .mac_rx       (mac_rx),
    .mac_tx       (mac_tx),
    .user_rx      (user_rx),
    .user_rx_meta (user_rx_meta),
    .user_tx      (user_tx),
    .user_tx_meta (user_tx_meta),
    .user_full    (user_full)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] next_byte();
    rng = xorshift32(rng);
    return rng[7:0];
  endfunction

  // 16-bit ones' complement sum, odd tail padded with zero
  function automatic logic [15:0] ones_sum(input logic [7:0] b [$]);
    logic [31:0] acc;
    acc = '0;
    for (int i = 0; i < b.size(); i += 2) begin
      acc += {16'd0, b[i], (i + 1 < b.size()) ? b[i + 1] : 8'h00};
    end
    while (acc[31:16] != '0) acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
    return acc[15:0];
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == test_base) ? "ok" : "errors");
    test_base = errors;
  endtask

  // IPv4 header in front of pay_q, len_field is the payload length it claims
  task automatic build_frame(input ip_pkg::ipv4_t src, input ip_pkg::ipv4_t dst,
                             input ip_pkg::proto_t proto, input int len_field,
                             input logic corrupt);
    logic [159:0] h;
    logic [15:0]  tot;
    logic [7:0]   tmp [$];
    tot = 16'(HDR + len_field);
    h   = {8'h45, 8'h00, tot, 16'h1234, 16'h4000, 8'(`IP_TTL), proto, 16'h0000, src, dst};
    for (int k = 0; k < HDR; k++) tmp.push_back(h[159 - 8 * k -: 8]);
    h[79:64] = ~ones_sum(tmp) ^ {15'd0, corrupt};
    pkt_q.delete();
    for (int k = 0; k < HDR; k++) pkt_q.push_back(h[159 - 8 * k -: 8]);
    foreach (pay_q[i]) pkt_q.push_back(pay_q[i]);
  endtask

  // echo request: type 8, code 0, checksum, id, sequence, data
  task automatic build_icmp(input int n);
    logic [15:0] cs;
    icmp_q.delete();
    icmp_q.push_back(8'h08);
    icmp_q.push_back(8'h00);
    icmp_q.push_back(8'h00);
    icmp_q.push_back(8'h00);
    icmp_q.push_back(8'hbe);
    icmp_q.push_back(8'hef);
    icmp_q.push_back(8'h00);
    icmp_q.push_back(8'h07);
    for (int i = 8; i < n; i++) icmp_q.push_back(next_byte());
    cs        = ~ones_sum(icmp_q);
    icmp_q[2] = cs[15:8];
    icmp_q[3] = cs[7:0];
    pay_q     = icmp_q;
  endtask

  task automatic send_mac();
    for (int i = 0; i < pkt_q.size(); i++) begin
      @(posedge clk);
      #10;
      mac_rx.data  = pkt_q[i];
      mac_rx.valid = 1'b1;
      mac_rx.sof   = (i == 0);
      mac_rx.eof   = (i == pkt_q.size() - 1);
    end
    @(posedge clk);
    #10;
    mac_rx = '0;
  endtask

  task automatic send_user(input ip_pkg::ipv4_t dst, input ip_pkg::proto_t proto);
    for (int i = 0; i < user_q.size(); i++) begin
      @(posedge clk);
      #10;
      user_tx.data       = user_q[i];
      user_tx.valid      = 1'b1;
      user_tx.eof        = (i == user_q.size() - 1);
      user_tx_meta.dst   = dst;
      user_tx_meta.proto = proto;
      user_tx_meta.len   = 16'(user_q.size());
    end
    @(posedge clk);
    #10;
    user_tx = '0;
  endtask

  task automatic take_tx();
    int n;
    while (tx_lens.size() == 0) @(negedge clk);
    n = tx_lens.pop_front();
    cur_q.delete();
    repeat (n) cur_q.push_back(tx_bytes.pop_front());
  endtask

  task automatic check_header(input ip_pkg::ipv4_t dst, input ip_pkg::proto_t proto,
                              input int pay_len);
    logic [7:0] hdr [$];
    compare_value("mac_tx packet length", HDR + pay_len, cur_q.size());
    if (cur_q.size() < HDR) begin
      $display("ERROR at %0t: mac_tx packet is shorter than an IPv4 header", $time);
      errors++;
    end else begin
      for (int i = 0; i < HDR; i++) hdr.push_back(cur_q[i]);
      compare_value("mac_tx version/IHL", 8'h45, cur_q[0]);
      compare_value("mac_tx total length", HDR + pay_len, {cur_q[2], cur_q[3]});
      compare_value("mac_tx flags", 8'h40, cur_q[6]);
      compare_value("mac_tx TTL", `IP_TTL, cur_q[8]);
      compare_value("mac_tx protocol", proto, cur_q[9]);
      compare_value("mac_tx source", DEV_IP, {cur_q[12], cur_q[13], cur_q[14], cur_q[15]});
      compare_value("mac_tx destination", dst, {cur_q[16], cur_q[17], cur_q[18], cur_q[19]});
      compare_value("mac_tx header sum", 16'hffff, ones_sum(hdr));
    end
  endtask

  task automatic check_user_pkt(input ip_pkg::ipv4_t dst, input ip_pkg::proto_t proto);
    check_header(dst, proto, user_q.size());
    for (int i = 0; i < user_q.size() && HDR + i < cur_q.size(); i++) begin
      compare_value($sformatf("mac_tx payload[%0d]", i), user_q[i], cur_q[HDR + i]);
    end
  endtask

  task automatic check_echo(input ip_pkg::ipv4_t req_src);
    logic [7:0] msg [$];
    check_header(req_src, 8'd1, icmp_q.size());
    for (int i = HDR; i < cur_q.size(); i++) msg.push_back(cur_q[i]);
    compare_value("ICMP length", icmp_q.size(), msg.size());
    if (msg.size() >= 8) begin
      compare_value("ICMP type", 8'h00, msg[0]);
      compare_value("ICMP code", icmp_q[1], msg[1]);
      for (int i = 4; i < msg.size() && i < icmp_q.size(); i++) begin
        compare_value($sformatf("ICMP byte %0d", i), icmp_q[i], msg[i]);
      end
      compare_value("ICMP checksum sum", 16'hffff, ones_sum(msg));
    end
  endtask

  task automatic check_rx(input int n, input logic exp_err);
    compare_value("user_rx byte count", n, rx_bytes.size());
    for (int i = 0; i < n && i < rx_bytes.size(); i++) begin
      compare_value($sformatf("user_rx.data[%0d]", i), pay_q[i], rx_bytes[i]);
    end
    compare_value("user_rx.err at eof", exp_err, rx_last_err);
  endtask

  // collects mac_tx packets
  always @(negedge clk) begin
    if (rst_n && mac_tx.valid) begin
      if (mac_tx.sof) tx_cnt = 0;
      tx_bytes.push_back(mac_tx.data);
      tx_cnt++;
      if (mac_tx.eof) tx_lens.push_back(tx_cnt);
      tx_open <= !mac_tx.eof;
    end
  end

  always @(negedge clk) begin
    if (rst_n && user_rx.valid) begin
      if (user_rx.sof) begin
        rx_bytes.delete();
        rx_meta_seen = user_rx_meta;
      end
      rx_bytes.push_back(user_rx.data);
      if (user_rx.eof) begin
        rx_last_err = user_rx.err;
        rx_pkts++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      $display("ERROR: timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  a_tx_sof: assert property (@(negedge clk) disable iff (!rst_n)
    mac_tx.valid && mac_tx.sof |-> !tx_open)
    else begin
      $display("ERROR at %0t: mac_tx sof arrived before the previous eof", $time);
      errors++;
    end

  a_tx_gap: assert property (@(negedge clk) disable iff (!rst_n)
    tx_open |-> mac_tx.valid)
    else begin
      $display("ERROR at %0t: mac_tx valid dropped inside a packet", $time);
      errors++;
    end

  a_tx_err: assert property (@(negedge clk) disable iff (!rst_n) !mac_tx.err)
    else begin
      $display("CHECK FAILED at %0t: mac_tx.err expected 0 actual 1", $time);
      errors++;
    end

  a_rx_quiet: assert property (@(negedge clk) disable iff (!rst_n)
    !rx_allowed |-> !user_rx.valid)
    else begin
      $display("CHECK FAILED at %0t: user_rx.valid expected 0 actual 1", $time);
      errors++;
    end

  a_tx_quiet: assert property (@(negedge clk) disable iff (!rst_n)
    !tx_allowed |-> !mac_tx.valid)
    else begin
      $display("CHECK FAILED at %0t: mac_tx.valid expected 0 actual 1", $time);
      errors++;
    end

  a_full_low: assert property (@(negedge clk) disable iff (!rst_n) !user_full)
    else begin
      $display("CHECK FAILED at %0t: user_full expected 0 actual 1", $time);
      errors++;
    end

  initial begin
    int n0;
    int n_echo;
    int n_user;
    rst_n        = 1'b0;
    dev_ip       = DEV_IP;
    mac_rx       = '0;
    user_tx      = '0;
    user_tx_meta = '0;
    repeat (5) @(posedge clk);
    #10;
    rst_n = 1'b1;

    repeat (20) begin
      @(negedge clk);
      compare_value("mac_tx.valid", 0, mac_tx.valid);
      compare_value("user_rx.valid", 0, user_rx.valid);
      compare_value("user_full", 0, user_full);
    end
    end_test("outputs idle after reset");

    tx_allowed = 1'b1;
    user_q.delete();
    repeat (USER_LEN) user_q.push_back(next_byte());
    send_user(USER_DST, 8'h11);
    take_tx();
    check_user_pkt(USER_DST, 8'h11);
    end_test("user packet framed on mac_tx");

    tx_allowed = 1'b0;
    rx_allowed = 1'b1;
    pay_q.delete();
    repeat (UDP_LEN) pay_q.push_back(next_byte());
    build_frame(PEER, DEV_IP, 8'd17, UDP_LEN, 1'b0);
    n0 = rx_pkts;
    send_mac();
    while (rx_pkts == n0) @(negedge clk);
    check_rx(UDP_LEN, 1'b0);
    compare_value("user_rx_meta.src", PEER, rx_meta_seen.src);
    compare_value("user_rx_meta.dst", DEV_IP, rx_meta_seen.dst);
    compare_value("user_rx_meta.proto", 17, rx_meta_seen.proto);
    compare_value("user_rx_meta.len", UDP_LEN, rx_meta_seen.len);
    @(posedge clk);
    #10;
    rx_allowed = 1'b0;   // foreign destination must vanish
    build_frame(PEER, DEV_IP ^ 32'h1, 8'd17, UDP_LEN, 1'b0);
    send_mac();
    repeat (10) @(posedge clk);
    end_test("receive to dev_ip and foreign drop");

    build_frame(PEER, DEV_IP, 8'd17, UDP_LEN, 1'b1);
    send_mac();
    repeat (10) @(posedge clk);
    #10;
    rx_allowed = 1'b1;
    pay_q.delete();
    repeat (TRUNC_SENT) pay_q.push_back(next_byte());
    build_frame(PEER, DEV_IP, 8'd17, TRUNC_LEN, 1'b0);
    n0 = rx_pkts;
    send_mac();
    while (rx_pkts == n0) @(negedge clk);
    check_rx(TRUNC_SENT, 1'b1);
    end_test("bad checksum and truncated packet");

    tx_allowed = 1'b1;
    build_icmp(ICMP_LEN);
    build_frame(PINGER, DEV_IP, 8'd1, ICMP_LEN, 1'b0);
    send_mac();
    take_tx();
    check_echo(PINGER);
    end_test("echo request answered");

    user_q.delete();
    repeat (USER_LEN) user_q.push_back(next_byte());
    build_icmp(ICMP_LEN);
    build_frame(PINGER, DEV_IP, 8'd1, ICMP_LEN, 1'b0);
    fork
      send_mac();
      send_user(USER_DST, 8'h11);
    join
    n_echo = 0;
    n_user = 0;
    repeat (2) begin
      take_tx();
      if (cur_q.size() > 9 && cur_q[9] == 8'd1) begin
        check_echo(PINGER);
        n_echo++;
      end else begin
        check_user_pkt(USER_DST, 8'h11);
        n_user++;
      end
    end
    compare_value("echo replies on mac_tx", 1, n_echo);
    compare_value("user packets on mac_tx", 1, n_user);
    end_test("user and echo traffic together");

    repeat (20) @(posedge clk);
    compare_value("unclaimed mac_tx packets", 0, tx_lens.size());
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule
